// File: Makefile
# Verilator build and run for the memory hub testbench

VERILATOR ?= verilator
TOP ?= memory_hub_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
FAIL_TEXT ?= ERRORS FOUND

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/hub_settings.svh
`ifndef HUB_SETTINGS_SVH
`define HUB_SETTINGS_SVH

// ------------------------------
// requesters
// ------------------------------

// channel 0 wins arbitration
`define HUB_CHANNELS 5

// ------------------------------
// address map
// ------------------------------

// flash from address zero up to this
`define HUB_FLASH_TOP 45'h040000000

// dram sits between flash top and io base
`define HUB_IO_BASE 45'h1FFFFFFF0000

// top 128 bytes of the io window, address bits 15..7 all ones
`define HUB_SYS_BASE 45'h1FFFFFFFFF80

// ------------------------------
// response buffering
// ------------------------------

// flash and io responses each get one fifo of this depth
`define HUB_FIFO_DEPTH 16

// ------------------------------
// system register indices
// ------------------------------

// index is address bits 6..3
// descriptor base and limit
`define HUB_REG_DESCRIPTOR 4'd0

// cpu number, core type, enable and lock
`define HUB_REG_CONTROL 4'd1

`endif

// File: source/hub_pkg.sv
`default_nettype none

package hub_pkg;

	// ------------------------------
	// request bus widths
	// ------------------------------

	// byte address
	typedef logic [44:0] addressT;

	// data word, eight byte lanes
	typedef logic [63:0] wordT;

	// one bit per lane, low means enabled
	typedef logic [7:0] byteEnableT;

	// 0 byte, 1 half, 2 word, 3 double
	typedef logic [1:0] sizeT;

	// ------------------------------
	// tags
	// ------------------------------

	// supplied by the requester, returned untouched
	typedef logic [12:0] channelTagT;
	typedef logic [2:0] channelIdT;

	// {byte offset, size, channel number, channel tag}
	typedef logic [20:0] routeTagT;

	// field positions inside the routing tag
	localparam int tagChannelLsb = $bits(channelTagT);
	localparam int tagSizeLsb = tagChannelLsb + $bits(channelIdT);
	localparam int tagOffsetLsb = tagSizeLsb + $bits(sizeT);

	// ------------------------------
	// misc
	// ------------------------------
	typedef logic [3:0] regIndexT;
	typedef logic [3:0] fillCountT;

endpackage : hub_pkg

`default_nettype wire

// File: source/memory_hub.sv
`default_nettype none
`timescale 1ns/1ps
`include "hub_settings.svh"

module memory_hub (
	input wire CLK,
	input wire RESETn,
	// requesting channels
	input wire logic [`HUB_CHANNELS-1:0] lAct,
	input wire logic [`HUB_CHANNELS-1:0] lCmd,
	input wire hub_pkg::sizeT lSize [`HUB_CHANNELS],
	input wire hub_pkg::addressT lAddr [`HUB_CHANNELS],
	input wire hub_pkg::wordT lDataOut [`HUB_CHANNELS],
	input wire hub_pkg::channelTagT lTagOut [`HUB_CHANNELS],
	output logic [`HUB_CHANNELS-1:0] lNext,
	output logic [`HUB_CHANNELS-1:0] lDrdy,
	output hub_pkg::wordT lDataIn,
	output hub_pkg::channelTagT lTagIn,
	output hub_pkg::sizeT lSizeIn,
	// shared request bus
	output logic cmd,
	output hub_pkg::addressT addr,
	output hub_pkg::wordT data,
	output hub_pkg::byteEnableT byteEn,
	output hub_pkg::routeTagT tag,
	// memory targets
	input wire flashNext,
	output logic flashAct,
	input wire flashDrdy,
	input wire hub_pkg::wordT flashData,
	input wire hub_pkg::routeTagT flashTag,
	input wire dramNext,
	output logic dramAct,
	input wire dramDrdy,
	input wire hub_pkg::wordT dramData,
	input wire hub_pkg::routeTagT dramTag,
	input wire ioNext,
	output logic ioAct,
	input wire ioDrdy,
	input wire hub_pkg::wordT ioData,
	input wire hub_pkg::routeTagT ioTag,
	// controller state
	input wire logic [7:0] coreType,
	output logic [39:0] descriptorBase,
	output logic [23:0] descriptorLimit,
	output logic [7:0] cpuNumber,
	output logic controllerEnable,
	output logic allocationLock
);
	import hub_pkg::*;

	logic sysAct, sysNext, sysDrdy;
	wordT sysData;
	routeTagT sysTag;

	request_arbiter request_arbiter_inst (.*);

	system_registers system_registers_inst (.*);

	response_merge response_merge_inst (.*);

endmodule : memory_hub

`default_nettype wire

// File: source/request_arbiter.sv
`default_nettype none
`timescale 1ns/1ps
`include "hub_settings.svh"

module request_arbiter (
	input wire CLK,
	input wire RESETn,
	input wire logic [`HUB_CHANNELS-1:0] lAct,
	input wire logic [`HUB_CHANNELS-1:0] lCmd,
	input wire hub_pkg::sizeT lSize [`HUB_CHANNELS],
	input wire hub_pkg::addressT lAddr [`HUB_CHANNELS],
	input wire hub_pkg::wordT lDataOut [`HUB_CHANNELS],
	input wire hub_pkg::channelTagT lTagOut [`HUB_CHANNELS],
	output logic [`HUB_CHANNELS-1:0] lNext,
	output logic cmd,
	output hub_pkg::addressT addr,
	output hub_pkg::wordT data,
	output hub_pkg::byteEnableT byteEn,
	output hub_pkg::routeTagT tag,
	input wire flashNext,
	input wire dramNext,
	input wire ioNext,
	input wire sysNext,
	output logic flashAct,
	output logic dramAct,
	output logic ioAct,
	output logic sysAct
);
	import hub_pkg::*;

	channelIdT grantId;
	addressT grantAddr;
	sizeT grantSize;
	logic [2:0] grantOffset;
	logic complete, accept, transfer, lowerActive;
	logic toFlash, toDram, toIo, toSys;

	// active-low lanes covered by the access, aligned to its size
	function automatic byteEnableT laneEnables(input logic [2:0] offset, input sizeT size);
		case (size)
			2'd0: return ~(8'b0000_0001 << offset);
			2'd1: return ~(8'b0000_0011 << {offset[2:1], 1'b0});
			2'd2: return ~(8'b0000_1111 << {offset[2], 2'b00});
			default: return 8'h00;
		endcase
	endfunction

	function automatic wordT replicate(input wordT value, input sizeT size);
		case (size)
			2'd0: return {8{value[7:0]}};
			2'd1: return {4{value[15:0]}};
			2'd2: return {2{value[31:0]}};
			default: return value;
		endcase
	endfunction

	// held request finishes this cycle
	always_comb begin
		complete = (flashAct & flashNext) | (dramAct & dramNext) | (ioAct & ioNext) |
			(sysAct & ~cmd) | (sysAct & cmd & sysNext);
		accept = ~(flashAct | dramAct | ioAct | sysAct) | complete;
		transfer = accept & (|lAct);
	end

	// lowest-numbered active channel wins
	always_comb begin
		grantId = '0;
		for (int i = `HUB_CHANNELS - 1; i >= 0; i--) begin
			if (lAct[i])
				grantId = channelIdT'(i);
		end
		lowerActive = 1'b0;
		for (int i = 0; i < `HUB_CHANNELS; i++) begin
			lNext[i] = accept & ~lowerActive;
			lowerActive = lowerActive | lAct[i];
		end
	end

	assign grantAddr = lAddr[grantId];
	assign grantSize = lSize[grantId];
	assign grantOffset = grantAddr[2:0];

	// ------------------------------
	// target decode
	// ------------------------------
	always_comb begin
		toSys = grantAddr >= `HUB_SYS_BASE;
		toIo = (grantAddr >= `HUB_IO_BASE) & ~toSys;
		toFlash = grantAddr < `HUB_FLASH_TOP;
		toDram = ~toFlash & (grantAddr < `HUB_IO_BASE);
	end

	// request bus, held until the request completes
	always_ff @(posedge CLK) begin
		if (transfer) begin
			cmd <= lCmd[grantId];
			addr <= grantAddr;
			data <= replicate(lDataOut[grantId], grantSize);
			byteEn <= laneEnables(grantOffset, grantSize);
			tag <= {grantOffset, grantSize, grantId, lTagOut[grantId]};
		end
	end

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			flashAct <= 1'b0;
			dramAct <= 1'b0;
			ioAct <= 1'b0;
			sysAct <= 1'b0;
		end else if (accept) begin
			flashAct <= transfer & toFlash;
			dramAct <= transfer & toDram;
			ioAct <= transfer & toIo;
			sysAct <= transfer & toSys;
		end
	end

endmodule : request_arbiter

`default_nettype wire

// File: source/response_fifo.sv
`default_nettype none
`timescale 1ns/1ps
`include "hub_settings.svh"

module response_fifo #(
	parameter int depth = `HUB_FIFO_DEPTH
) (
	input wire CLK,
	input wire RESETn,
	input wire write,
	input wire logic [$bits(hub_pkg::routeTagT) + $bits(hub_pkg::wordT) - 1:0] writeData,
	input wire read,
	output logic [$bits(hub_pkg::routeTagT) + $bits(hub_pkg::wordT) - 1:0] readData,
	output logic empty,
	output hub_pkg::fillCountT used
);
	import hub_pkg::*;

	localparam int width = $bits(routeTagT) + $bits(wordT);
	localparam int pointerBits = $clog2(depth);
	localparam logic [pointerBits-1:0] lastIndex = pointerBits'(depth - 1);
	localparam logic [pointerBits:0] fullCount = (pointerBits + 1)'(depth);
	localparam logic [pointerBits:0] fillLimit = (pointerBits + 1)'(2 ** $bits(fillCountT) - 1);

	logic [width-1:0] storage [depth];
	logic [pointerBits-1:0] writePtr, readPtr;
	logic [pointerBits:0] count;
	logic doWrite, doRead;

	function automatic logic [pointerBits-1:0] advance(input logic [pointerBits-1:0] ptr);
		return (ptr == lastIndex) ? '0 : ptr + 1'b1;
	endfunction

	// show-ahead, head entry always on readData
	always_comb begin
		empty = (count == '0);
		doRead = read & ~empty;
		doWrite = write & ((count != fullCount) | doRead);
		readData = storage[readPtr];
		// full fifo reports the largest count the port can carry
		used = (count > fillLimit) ? fillCountT'(fillLimit) : fillCountT'(count);
	end

	always_ff @(posedge CLK) begin
		if (doWrite)
			storage[writePtr] <= writeData;
	end

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			writePtr <= '0;
			readPtr <= '0;
			count <= '0;
		end else begin
			if (doWrite)
				writePtr <= advance(writePtr);
			if (doRead)
				readPtr <= advance(readPtr);
			case ({doWrite, doRead})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule : response_fifo

`default_nettype wire

// File: source/response_merge.sv
`default_nettype none
`timescale 1ns/1ps
`include "hub_settings.svh"

module response_merge (
	input wire CLK,
	input wire RESETn,
	input wire flashDrdy,
	input wire hub_pkg::wordT flashData,
	input wire hub_pkg::routeTagT flashTag,
	input wire ioDrdy,
	input wire hub_pkg::wordT ioData,
	input wire hub_pkg::routeTagT ioTag,
	input wire dramDrdy,
	input wire hub_pkg::wordT dramData,
	input wire hub_pkg::routeTagT dramTag,
	input wire sysDrdy,
	input wire hub_pkg::wordT sysData,
	input wire hub_pkg::routeTagT sysTag,
	output logic [`HUB_CHANNELS-1:0] lDrdy,
	output hub_pkg::wordT lDataIn,
	output hub_pkg::channelTagT lTagIn,
	output hub_pkg::sizeT lSizeIn
);
	import hub_pkg::*;

	localparam int entryBits = $bits(routeTagT) + $bits(wordT);

	logic [entryBits-1:0] flashEntry, ioEntry;
	logic flashEmpty, ioEmpty, flashRead, ioRead, fifoTurn, ioFirst;
	fillCountT flashUsed, ioUsed;
	logic stageValid;
	routeTagT stageTag;
	wordT stageData, laneData;
	sizeT stageSize;
	channelIdT stageChannel;
	logic [2:0] laneOffset;

	response_fifo #(.depth(`HUB_FIFO_DEPTH)) flashFifo (
		.CLK(CLK), .RESETn(RESETn),
		.write(flashDrdy), .writeData({flashTag, flashData}), .read(flashRead),
		.readData(flashEntry), .empty(flashEmpty), .used(flashUsed)
	);

	response_fifo #(.depth(`HUB_FIFO_DEPTH)) ioFifo (
		.CLK(CLK), .RESETn(RESETn),
		.write(ioDrdy), .writeData({ioTag, ioData}), .read(ioRead),
		.readData(ioEntry), .empty(ioEmpty), .used(ioUsed)
	);

	// fifos only get a turn when dram and sys are quiet; io wins a tie
	always_comb begin
		fifoTurn = ~dramDrdy & ~sysDrdy;
		ioFirst = ioUsed >= flashUsed;
		ioRead = fifoTurn & ioFirst;
		flashRead = fifoTurn & ~ioFirst;
	end

	// ------------------------------
	// stage 1, source select
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (dramDrdy)
			{stageTag, stageData} <= {dramTag, dramData};
		else if (sysDrdy)
			{stageTag, stageData} <= {sysTag, sysData};
		else if (ioFirst)
			{stageTag, stageData} <= ioEntry;
		else
			{stageTag, stageData} <= flashEntry;
	end

	always_ff @(posedge CLK) begin
		if (!RESETn)
			stageValid <= 1'b0;
		else
			stageValid <= dramDrdy | sysDrdy | (ioRead & ~ioEmpty) | (flashRead & ~flashEmpty);
	end

	// addressed lanes down to bit 0, upper bits cleared
	always_comb begin
		stageSize = stageTag[tagSizeLsb +: $bits(sizeT)];
		stageChannel = stageTag[tagChannelLsb +: $bits(channelIdT)];
		laneOffset = stageTag[tagOffsetLsb +: 3];
		case (stageSize)
			2'd0: laneData = {56'd0, stageData[{laneOffset, 3'b000} +: 8]};
			2'd1: laneData = {48'd0, stageData[{laneOffset[2:1], 4'b0000} +: 16]};
			2'd2: laneData = {32'd0, stageData[{laneOffset[2], 5'b00000} +: 32]};
			default: laneData = stageData;
		endcase
	end

	// ------------------------------
	// stage 2, channel strobes
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			lDrdy <= '0;
		end else begin
			for (int i = 0; i < `HUB_CHANNELS; i++)
				lDrdy[i] <= stageValid & (stageChannel == channelIdT'(i));
		end
	end

	always_ff @(posedge CLK) begin
		lDataIn <= laneData;
		lTagIn <= stageTag[$bits(channelTagT)-1:0];
		lSizeIn <= stageSize;
	end

endmodule : response_merge

`default_nettype wire

// File: source/system_registers.sv
`default_nettype none
`timescale 1ns/1ps
`include "hub_settings.svh"

module system_registers (
	input wire CLK,
	input wire RESETn,
	input wire sysAct,
	input wire cmd,
	input wire hub_pkg::addressT addr,
	input wire hub_pkg::byteEnableT byteEn,
	input wire hub_pkg::wordT data,
	input wire dramDrdy,
	input wire hub_pkg::routeTagT tag,
	input wire logic [7:0] coreType,
	output logic sysNext,
	output logic sysDrdy,
	output hub_pkg::wordT sysData,
	output hub_pkg::routeTagT sysTag,
	output logic [39:0] descriptorBase,
	output logic [23:0] descriptorLimit,
	output logic [7:0] cpuNumber,
	output logic controllerEnable,
	output logic allocationLock
);
	import hub_pkg::*;

	regIndexT regIndex;
	wordT descriptorWord, readWord;
	logic writeStrobe, readAccept;

	assign regIndex = addr[6:3];
	assign descriptorBase = descriptorWord[39:0];
	assign descriptorLimit = descriptorWord[63:40];

	// a pending read response stalls only while dram is returning data
	always_comb begin
		sysNext = ~sysDrdy | ~dramDrdy;
		writeStrobe = sysAct & ~cmd;
		readAccept = sysAct & cmd & sysNext;
	end

	always_comb begin
		case (regIndex)
			`HUB_REG_DESCRIPTOR: readWord = descriptorWord;
			// enable, lock, core type, cpu number
			`HUB_REG_CONTROL: readWord = {32'd0, controllerEnable, allocationLock, 6'd0,
				coreType, 8'd0, cpuNumber};
			default: readWord = '0;
		endcase
	end

	// ------------------------------
	// byte-enabled writes
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			descriptorWord <= '0;
			cpuNumber <= '0;
			controllerEnable <= 1'b0;
			allocationLock <= 1'b0;
		end else if (writeStrobe) begin
			if (regIndex == `HUB_REG_DESCRIPTOR) begin
				for (int b = 0; b < 8; b++) begin
					if (!byteEn[b])
						descriptorWord[8*b +: 8] <= data[8*b +: 8];
				end
			end
			if (regIndex == `HUB_REG_CONTROL) begin
				if (!byteEn[0])
					cpuNumber <= data[7:0];
				// byte 2 is core type, read only
				if (!byteEn[3]) begin
					controllerEnable <= data[31];
					allocationLock <= data[30];
				end
			end
		end
	end

	// ------------------------------
	// read response
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn)
			sysDrdy <= 1'b0;
		else
			sysDrdy <= (sysDrdy & dramDrdy) | readAccept;
	end

	always_ff @(posedge CLK) begin
		if (readAccept) begin
			sysData <= readWord;
			sysTag <= tag;
		end
	end

endmodule : system_registers

`default_nettype wire

// File: verif/memory_hub_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "hub_settings.svh"

module memory_hub_tb;
	import hub_pkg::*;

	typedef logic [`HUB_CHANNELS-1:0] channelMaskT;

	localparam int tagLimit = 8192;
	localparam int drainLimit = 2000;

	logic CLK, RESETn;
	logic [`HUB_CHANNELS-1:0] lAct, lCmd, lNext, lDrdy;
	sizeT lSize [`HUB_CHANNELS];
	addressT lAddr [`HUB_CHANNELS];
	wordT lDataOut [`HUB_CHANNELS];
	channelTagT lTagOut [`HUB_CHANNELS];
	wordT lDataIn, data, flashData, dramData, ioData;
	channelTagT lTagIn;
	sizeT lSizeIn;
	logic cmd, flashNext, flashAct, flashDrdy, dramNext, dramAct, dramDrdy;
	logic ioNext, ioAct, ioDrdy, controllerEnable, allocationLock;
	addressT addr;
	byteEnableT byteEn;
	routeTagT tag, flashTag, dramTag, ioTag;
	logic [7:0] coreType, cpuNumber;
	logic [39:0] descriptorBase;
	logic [23:0] descriptorLimit;

	// target models, index 0 flash, 1 dram, 2 io
	logic [2:0] targetAct, targetNext, targetDrdy;
	wordT targetData [3];
	routeTagT targetTag [3];
	addressT pendAddr [3][64];
	routeTagT pendTag [3][64];
	int pendHead [3], pendTail [3], respDelay [3];

	// expected responses, keyed by the unique channel tag
	logic expPending [tagLimit];
	channelIdT expChannel [tagLimit];
	sizeT expSize [tagLimit];
	wordT expData [tagLimit];
	int expSource [tagLimit];
	channelTagT order [4][$];

	// register model and grant bookkeeping
	wordT regDescriptor;
	logic [7:0] regCpu;
	logic regEnable, regLock, grantValid, gCmd, sysBusy;
	int gCh, nextTag, mismatches, failures, waited;
	addressT gAddr, heldAddr;
	sizeT gSize;
	wordT gData, heldData;
	channelTagT gTag;
	routeTagT heldTag;
	byteEnableT heldByteEn;
	logic [2:0] stalledPrev;

	memory_hub memory_hub_inst (.*);

	assign targetAct = {ioAct, dramAct, flashAct};
	assign {ioNext, dramNext, flashNext} = targetNext;
	assign {ioDrdy, dramDrdy, flashDrdy} = targetDrdy;
	assign flashData = targetData[0];
	assign dramData = targetData[1];
	assign ioData = targetData[2];
	assign flashTag = targetTag[0];
	assign dramTag = targetTag[1];
	assign ioTag = targetTag[2];

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic addressCompare(input string name, input addressT got, input addressT want);
		if (got !== want) begin
			$display("mismatch %s: got %h, expected %h", name, got, want);
			mismatches++;
		end
	endtask

	task automatic byteEnableCompare(input string name, input byteEnableT got,
		input byteEnableT want);
		if (got !== want) begin
			$display("mismatch %s: got %h, expected %h", name, got, want);
			mismatches++;
		end
	endtask

	task automatic wordCompare(input string name, input wordT got, input wordT want);
		if (got !== want) begin
			$display("mismatch %s: got %h, expected %h", name, got, want);
			mismatches++;
		end
	endtask

	task automatic routeTagCompare(input string name, input routeTagT got, input routeTagT want);
		if (got !== want) begin
			$display("mismatch %s: got %h, expected %h", name, got, want);
			mismatches++;
		end
	endtask

	task automatic sizeCompare(input string name, input sizeT got, input sizeT want);
		if (got !== want) begin
			$display("mismatch %s: got %h, expected %h", name, got, want);
			mismatches++;
		end
	endtask

	task automatic maskCompare(input string name, input channelMaskT got, input channelMaskT want);
		if (got !== want) begin
			$display("mismatch %s: got %h, expected %h", name, got, want);
			mismatches++;
		end
	endtask

	task automatic bitCompare(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("mismatch %s: got %h, expected %h", name, got, want);
			mismatches++;
		end
	endtask

	// ------------------------------
	// reference model
	// ------------------------------

	// fill pattern over all 45 address bits
	function automatic wordT memWord(input addressT a);
		return {a, 19'h5A3C1} ^ {19'h2E6B7, a} ^ 64'hC3A5_96E1_0F1E_2D3C;
	endfunction

	function automatic wordT registerWord(input regIndexT index);
		if (index == `HUB_REG_DESCRIPTOR)
			return regDescriptor;
		if (index == `HUB_REG_CONTROL)
			return {32'd0, regEnable, regLock, 6'd0, coreType, 8'd0, regCpu};
		return '0;
	endfunction

	// target 0 flash, 1 dram, 2 io, 3 system registers
	function automatic void referenceRequest(input addressT a, input sizeT s, input wordT value,
		output byteEnableT be, output wordT rep, output int target, output wordT resp);
		int bytes, first;
		wordT stored;
		bytes = 1 << s;
		first = (int'(a[2:0]) / bytes) * bytes;
		for (int b = 0; b < 8; b++) begin
			be[b] = !(b >= first && b < first + bytes);
			rep[8*b +: 8] = value[8*(b % bytes) +: 8];
		end
		if (a < `HUB_FLASH_TOP)
			target = 0;
		else if (a < `HUB_IO_BASE)
			target = 1;
		else if (&a[15:7])
			target = 3;
		else
			target = 2;
		stored = (target == 3) ? registerWord(a[6:3]) : memWord(a);
		resp = stored >> (8 * first);
		if (bytes < 8)
			resp = resp & ((64'd1 << (8 * bytes)) - 64'd1);
	endfunction

	task automatic registerWrite(input regIndexT index, input byteEnableT be, input wordT value);
		if (index == `HUB_REG_DESCRIPTOR) begin
			for (int b = 0; b < 8; b++) begin
				if (!be[b])
					regDescriptor[8*b +: 8] = value[8*b +: 8];
			end
		end
		if (index == `HUB_REG_CONTROL) begin
			if (!be[0])
				regCpu = value[7:0];
			if (!be[3])
				{regEnable, regLock} = value[31:30];
		end
	endtask

	function automatic int outstanding();
		return order[0].size() + order[1].size() + order[2].size() + order[3].size();
	endfunction

	// ------------------------------
	// channel stimulus
	// ------------------------------
	task automatic requestStart(input int i);
		int kind, sysIndex;
		kind = $urandom % 8;
		sysIndex = ($urandom % 3 == 0) ? $urandom % 16 : $urandom % 2;
		lCmd[i] = ($urandom % 4) != 0;
		lSize[i] = sizeT'($urandom);
		lDataOut[i] = {$urandom, $urandom};
		lTagOut[i] = channelTagT'(nextTag);
		nextTag++;
		case (kind)
			0, 1: lAddr[i] = addressT'($urandom % 32'h4000_0000);
			2, 3: lAddr[i] = `HUB_FLASH_TOP + addressT'($urandom);
			4, 5: lAddr[i] = `HUB_IO_BASE + addressT'($urandom % 32'h8000);
			default: begin
				// more writes here so the registers see traffic
				lCmd[i] = ($urandom % 2) != 0;
				lAddr[i] = `HUB_SYS_BASE + addressT'(sysIndex * 8 + $urandom % 8);
			end
		endcase
		lAct[i] = 1'b1;
	endtask

	task automatic channelDrive(input bit allowNew);
		for (int i = 0; i < `HUB_CHANNELS; i++) begin
			if (grantValid && gCh == i)
				lAct[i] = 1'b0;
			if (!lAct[i] && allowNew && $urandom % 3 == 0)
				requestStart(i);
		end
		grantValid = 1'b0;
	endtask

	// bus one cycle after the transfer edge
	task automatic transferCheck;
		byteEnableT wantBe;
		wordT wantData, wantResp;
		int target;
		referenceRequest(gAddr, gSize, gData, wantBe, wantData, target, wantResp);
		addressCompare("addr", addr, gAddr);
		bitCompare("cmd", cmd, gCmd);
		byteEnableCompare("byteEn", byteEn, wantBe);
		wordCompare("data", data, wantData);
		routeTagCompare("tag", tag, {gAddr[2:0], gSize, channelIdT'(gCh), gTag});
		bitCompare("flashAct", flashAct, target == 0);
		bitCompare("dramAct", dramAct, target == 1);
		bitCompare("ioAct", ioAct, target == 2);
		bitCompare("sysAct", memory_hub_inst.sysAct, target == 3);
		if (gCmd) begin
			expPending[gTag] = 1'b1;
			expChannel[gTag] = channelIdT'(gCh);
			expSize[gTag] = gSize;
			expData[gTag] = wantResp;
			expSource[gTag] = target;
			order[target].push_back(gTag);
		end else if (target == 3) begin
			registerWrite(gAddr[6:3], wantBe, wantData);
		end
	endtask

	task automatic arbitrationCheck;
		int lowest;
		logic acceptNow, memDone, memStall;
		channelMaskT priorityMask;
		lowest = -1;
		for (int i = `HUB_CHANNELS - 1; i >= 0; i--) begin
			if (lAct[i])
				lowest = i;
		end
		for (int i = 0; i < `HUB_CHANNELS; i++)
			priorityMask[i] = (lowest < 0) || (i <= lowest);
		memDone = |(targetAct & targetNext);
		memStall = |(targetAct & ~targetNext);
		if (memStall)
			acceptNow = 1'b0;
		else if (memDone || !memory_hub_inst.sysAct)
			acceptNow = 1'b1;
		else if (!cmd)
			acceptNow = 1'b1;
		else
			// system read, waits while a pending response meets dram data
			acceptNow = !(sysBusy && targetDrdy[1]);
		maskCompare("lNext", lNext, acceptNow ? priorityMask : '0);
		// read response pending in the next cycle
		sysBusy = (sysBusy && targetDrdy[1]) || (memory_hub_inst.sysAct && cmd && acceptNow);
		if (lowest >= 0 && lNext[lowest]) begin
			grantValid = 1'b1;
			gCh = lowest;
			gAddr = lAddr[lowest];
			gSize = lSize[lowest];
			gCmd = lCmd[lowest];
			gData = lDataOut[lowest];
			gTag = lTagOut[lowest];
		end
	endtask

	// a stalled target keeps act and the bus steady
	task automatic stallCheck;
		if (stalledPrev != '0) begin
			if ((targetAct & stalledPrev) != stalledPrev) begin
				$display("target act dropped while its next level was low");
				failures++;
			end
			addressCompare("addr while stalled", addr, heldAddr);
			wordCompare("data while stalled", data, heldData);
			byteEnableCompare("byteEn while stalled", byteEn, heldByteEn);
			routeTagCompare("tag while stalled", tag, heldTag);
		end
		stalledPrev = targetAct & ~targetNext;
		heldAddr = addr;
		heldData = data;
		heldByteEn = byteEn;
		heldTag = tag;
	endtask

	task automatic cycle(input bit allowNew);
		@(posedge CLK);
		#0.5;
		if (grantValid)
			transferCheck();
		channelDrive(allowNew);
		@(negedge CLK);
		arbitrationCheck();
		stallCheck();
	endtask

	task automatic quietCheck;
		bitCompare("flashAct", flashAct, 1'b0);
		bitCompare("dramAct", dramAct, 1'b0);
		bitCompare("ioAct", ioAct, 1'b0);
		bitCompare("sysAct", memory_hub_inst.sysAct, 1'b0);
		maskCompare("lDrdy", lDrdy, '0);
	endtask

	// ------------------------------
	// responses
	// ------------------------------
	task automatic responseCheck;
		channelTagT t;
		int src, found;
		t = lTagIn;
		if ($countones(lDrdy) != 1) begin
			$display("more than one lDrdy bit is high at once: %h", lDrdy);
			failures++;
		end
		if (!expPending[t]) begin
			$display("response with tag %h matches no outstanding read", t);
			failures++;
		end else begin
			maskCompare("lDrdy", lDrdy, channelMaskT'(1) << expChannel[t]);
			sizeCompare("lSizeIn", lSizeIn, expSize[t]);
			wordCompare("lDataIn", lDataIn, expData[t]);
			src = expSource[t];
			found = -1;
			for (int k = order[src].size() - 1; k >= 0; k--) begin
				if (order[src][k] == t)
					found = k;
			end
			if (found != 0) begin
				$display("response with tag %h came back out of order for its source", t);
				failures++;
			end
			if (found >= 0)
				order[src].delete(found);
			expPending[t] = 1'b0;
		end
	endtask

	always @(negedge CLK) begin
		if (RESETn === 1'b1 && lDrdy != '0)
			responseCheck();
	end

	// flash, dram and io answer each accepted read once
	always @(posedge CLK) begin
		#0.5;
		for (int k = 0; k < 3; k++) begin
			if (respDelay[k] > 0)
				respDelay[k]--;
			targetDrdy[k] = 1'b0;
			if (respDelay[k] == 0 && pendHead[k] != pendTail[k]) begin
				targetDrdy[k] = 1'b1;
				targetData[k] = memWord(pendAddr[k][pendHead[k]]);
				targetTag[k] = pendTag[k][pendHead[k]];
				pendHead[k] = (pendHead[k] + 1) % 64;
				respDelay[k] = $urandom % 6;
			end
			targetNext[k] = ($urandom % 4) != 0;
			if (targetAct[k] && targetNext[k] && cmd) begin
				pendAddr[k][pendTail[k]] = addr;
				pendTag[k][pendTail[k]] = tag;
				pendTail[k] = (pendTail[k] + 1) % 64;
			end
		end
	end

	initial begin
		void'($urandom(32'h9aba_8915));
		RESETn = 1'b0;
		coreType = 8'h5C;
		lAct = '0;
		lCmd = '0;
		for (int i = 0; i < `HUB_CHANNELS; i++) begin
			lSize[i] = '0;
			lAddr[i] = '0;
			lDataOut[i] = '0;
			lTagOut[i] = '0;
		end
		targetNext = '0;
		targetDrdy = '0;
		for (int k = 0; k < 3; k++) begin
			targetData[k] = '0;
			targetTag[k] = '0;
			pendHead[k] = 0;
			pendTail[k] = 0;
			respDelay[k] = 0;
		end
		for (int t = 0; t < tagLimit; t++)
			expPending[t] = 1'b0;
		regDescriptor = '0;
		regCpu = '0;
		regEnable = 1'b0;
		regLock = 1'b0;
		grantValid = 1'b0;
		sysBusy = 1'b0;
		stalledPrev = '0;
		nextTag = 0;
		mismatches = 0;
		failures = 0;
		repeat (5) @(posedge CLK);
		#0.5;
		RESETn = 1'b1;
		repeat (3) begin
			cycle(1'b0);
			quietCheck();
		end
		repeat (1500) cycle(1'b1);
		// drain remaining requests and responses
		waited = 0;
		while ((lAct != '0 || outstanding() != 0 || targetAct != '0 ||
			memory_hub_inst.sysAct) && waited < drainLimit) begin
			cycle(1'b0);
			waited++;
		end
		if (waited >= drainLimit) begin
			$display("timed out waiting for %0d outstanding responses", outstanding());
			failures++;
		end
		wordCompare("descriptor word", {descriptorLimit, descriptorBase}, regDescriptor);
		wordCompare("cpuNumber", wordT'(cpuNumber), wordT'(regCpu));
		bitCompare("controllerEnable", controllerEnable, regEnable);
		bitCompare("allocationLock", allocationLock, regLock);
		$display("mismatches %0d, other failures %0d", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule : memory_hub_tb

`default_nettype wire

// File: verilog.f
+incdir+include
source/hub_pkg.sv
source/request_arbiter.sv
source/response_fifo.sv
source/response_merge.sv
source/system_registers.sv
source/memory_hub.sv
verif/memory_hub_tb.sv
